//--- Makefile
# Verilator build and run of the decoder testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- design/decode_collector.sv
`timescale 1ns/1ps

module decode_collector import decode_pkg::*; #(
  parameter int NUM_LANES   = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic [NUM_LANES-1:0] res_valid_i,
  input  decoded_instr_t       res_i [NUM_LANES],
  output logic [NUM_LANES-1:0] take_o,
  input  logic                 credit_i,
  output logic                 out_valid_o,
  output decoded_instr_t       out_instr_o
);

  localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam int CRED_W = $clog2(OUT_CREDITS + 1);
  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(NUM_LANES - 1);

  logic [LANE_W-1:0] rd_ptr_q;
  logic [CRED_W-1:0] credit_q;
  logic              out_valid_q;
  decoded_instr_t    out_q;
  logic              take;

  // Same lane order as dispatch keeps program order
  assign take = res_valid_i[rd_ptr_q] && (credit_q != '0);

  always_comb begin
    take_o = '0;
    if (take) take_o[rd_ptr_q] = 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (take) out_q <= res_i[rd_ptr_q];
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_q    <= '0;
      credit_q    <= CRED_W'(OUT_CREDITS);
      out_valid_q <= 1'b0;
    end else begin
      out_valid_q <= take;
      if (take) rd_ptr_q <= (rd_ptr_q == LAST_LANE) ? '0 : rd_ptr_q + 1'b1;
      if (credit_i && !take) credit_q <= credit_q + 1'b1;
      else if (!credit_i && take) credit_q <= credit_q - 1'b1;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_instr_o = out_q;

  a_credit_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    credit_q <= CRED_W'(OUT_CREDITS))
    else $error("decode_collector: more credits returned than issued");

endmodule

//--- design/decode_lane.sv
`timescale 1ns/1ps

module decode_lane import decode_pkg::*; (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           valid_i,
  input  fetched_instr_t instr_i,
  output logic           busy_o,
  output logic           res_valid_o,
  output decoded_instr_t res_o,
  input  logic           take_i
);

  instr_word_u    w;
  decoded_instr_t dec;
  decoded_instr_t res_q;
  logic           res_valid_q;
  logic           rd_en, rs1_en, rs2_en;
  logic           illegal, ecall, ebreak;
  logic [XLEN-1:0] i_imm, s_imm, b_imm, u_imm, j_imm;

  assign w = instr_i.instr;

  //////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////

  assign i_imm = {{52{w.r.funct7[6]}}, w.r.funct7, w.r.rs2};
  assign s_imm = {{52{w.r.funct7[6]}}, w.r.funct7, w.r.rd};
  assign b_imm = {{52{w.r.funct7[6]}}, w.r.rd[0], w.r.funct7[5:0], w.r.rd[4:1], 1'b0};
  assign u_imm = {{32{w.u.imm[19]}}, w.u.imm, 12'b0};
  assign j_imm = {{44{w.r.funct7[6]}}, w.r.rs1, w.r.funct3, w.r.rs2[0],
                  w.r.funct7[5:0], w.r.rs2[4:1], 1'b0};

  //////////////////////////////////////////////////
  // Field decode
  //////////////////////////////////////////////////

  always_comb begin
    dec     = DECODED_DEFAULT;
    rd_en   = 1'b0;
    rs1_en  = 1'b0;
    rs2_en  = 1'b0;
    illegal = 1'b0;
    ecall   = 1'b0;
    ebreak  = 1'b0;
    dec.pc  = instr_i.pc;

    case (w.r.opcode)
      OPCODE_JAL: begin
        dec.op_type = OP_JUMP;
        rd_en = 1'b1;
      end
      OPCODE_JALR: begin
        dec.op_type = OP_JUMP;
        rd_en = 1'b1;
        rs1_en = 1'b1;
        if (w.r.funct3 != 3'b000) illegal = 1'b1;
      end
      OPCODE_BRANCH: begin
        dec.op_type = OP_BRANCH;
        rs1_en = 1'b1;
        rs2_en = 1'b1;
        dec.condition = condition_e'(w.r.funct3);
        if (w.r.funct3[2:1] == 2'b01) illegal = 1'b1;
      end
      OPCODE_LOAD: begin
        dec.op_type = OP_MEM;
        dec.mem_op = MEM_LOAD;
        dec.size = w.r.funct3[1:0];
        dec.zero_ext = w.r.funct3[2];
        rd_en = 1'b1;
        rs1_en = 1'b1;
        if (w.r.funct3 == 3'b111) illegal = 1'b1;
      end
      OPCODE_STORE: begin
        dec.op_type = OP_MEM;
        dec.mem_op = MEM_STORE;
        dec.size = w.r.funct3[1:0];
        rs1_en = 1'b1;
        rs2_en = 1'b1;
        if (w.r.funct3[2]) illegal = 1'b1;
      end
      OPCODE_LUI, OPCODE_AUIPC: rd_en = 1'b1;
      OPCODE_OP_IMM, OPCODE_OP_IMM_32: begin
        dec.word_op = w.r.opcode[3];
        rd_en = 1'b1;
        rs1_en = 1'b1;
        case (w.r.funct3)
          3'b000: dec.alu_op = ALU_ADD;
          3'b010: {dec.alu_op, dec.condition} = {ALU_SCC, CC_LT};
          3'b011: {dec.alu_op, dec.condition} = {ALU_SCC, CC_LTU};
          3'b100: dec.alu_op = ALU_XOR;
          3'b110: dec.alu_op = ALU_OR;
          3'b111: dec.alu_op = ALU_AND;
          3'b001: begin
            dec.alu_op = ALU_SHIFT;
            dec.shift_op = SHIFT_OP_SLL;
          end
          default: begin
            dec.alu_op = ALU_SHIFT;
            dec.shift_op = w.r.funct7[5] ? SHIFT_OP_SRA : SHIFT_OP_SRL;
          end
        endcase
        // Word forms have no 32-bit logic ops, shamt is limited to 5 bits
        if (dec.word_op && !(w.r.funct3 inside {3'b000, 3'b001, 3'b101})) illegal = 1'b1;
        if (w.r.funct3 == 3'b001 && (w.r.funct7[6:1] != 6'b0 || (dec.word_op && w.r.funct7[0])))
          illegal = 1'b1;
        if (w.r.funct3 == 3'b101 && ({w.r.funct7[6], w.r.funct7[4:1]} != 5'b0 ||
            (dec.word_op && w.r.funct7[0])))
          illegal = 1'b1;
      end
      OPCODE_OP, OPCODE_OP_32: begin
        dec.word_op = w.r.opcode[3];
        rd_en = 1'b1;
        rs1_en = 1'b1;
        rs2_en = 1'b1;
        casez ({w.r.funct7, w.r.funct3})
          {7'b0000001, 3'b0??}: begin
            dec.op_type = OP_MUL;
            dec.mul_div_op = w.r.funct3[1:0];
            if (dec.word_op && w.r.funct3 != 3'b000) illegal = 1'b1;
          end
          {7'b0000001, 3'b1??}: begin
            dec.op_type = OP_DIV;
            dec.mul_div_op = w.r.funct3[1:0];
          end
          {7'b0000000, 3'b000}: dec.alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: dec.alu_op = ALU_SUB;
          {7'b0000000, 3'b001}: dec.alu_op = ALU_SHIFT;
          {7'b0000000, 3'b101}: {dec.alu_op, dec.shift_op} = {ALU_SHIFT, SHIFT_OP_SRL};
          {7'b0100000, 3'b101}: {dec.alu_op, dec.shift_op} = {ALU_SHIFT, SHIFT_OP_SRA};
          {7'b0000000, 3'b010}: {dec.alu_op, dec.condition} = {ALU_SCC, CC_LT};
          {7'b0000000, 3'b011}: {dec.alu_op, dec.condition} = {ALU_SCC, CC_LTU};
          {7'b0000000, 3'b100}: dec.alu_op = ALU_XOR;
          {7'b0000000, 3'b110}: dec.alu_op = ALU_OR;
          {7'b0000000, 3'b111}: dec.alu_op = ALU_AND;
          default: illegal = 1'b1;
        endcase
        if (dec.word_op && dec.op_type == OP_ALU && !(w.r.funct3 inside {3'b000, 3'b001, 3'b101}))
          illegal = 1'b1;
      end
      // FENCE only, decoded as a no-op ALU add
      OPCODE_MISC_MEM: if (w.r.funct3 != 3'b000) illegal = 1'b1;
      OPCODE_SYSTEM: begin
        if (w.r.funct3 != 3'b000) illegal = 1'b1;
        else if ({w.r.funct7, w.r.rs2} == 12'h000) ecall = 1'b1;
        else if ({w.r.funct7, w.r.rs2} == 12'h001) ebreak = 1'b1;
        else illegal = 1'b1;
      end
      default: illegal = 1'b1;
    endcase

    dec.rd  = rd_en  ? w.r.rd  : 5'd0;
    dec.rs1 = rs1_en ? w.r.rs1 : 5'd0;
    dec.rs2 = rs2_en ? w.r.rs2 : 5'd0;

    // Adder and ALU operand select
    case (w.r.opcode)
      OPCODE_LOAD, OPCODE_STORE, OPCODE_LUI, OPCODE_JALR: dec.adder_use_imm = 1'b1;
      OPCODE_OP_IMM, OPCODE_OP_IMM_32: {dec.adder_use_imm, dec.use_imm} = 2'b11;
      OPCODE_AUIPC, OPCODE_JAL, OPCODE_BRANCH: {dec.adder_use_pc, dec.adder_use_imm} = 2'b11;
      default: ;
    endcase

    case (w.r.opcode)
      OPCODE_LOAD, OPCODE_OP_IMM, OPCODE_OP_IMM_32, OPCODE_JALR: dec.immediate = i_imm;
      OPCODE_LUI, OPCODE_AUIPC: dec.immediate = u_imm;
      OPCODE_STORE:  dec.immediate = s_imm;
      OPCODE_BRANCH: dec.immediate = b_imm;
      OPCODE_JAL:    dec.immediate = j_imm;
      default: ;
    endcase

    // Illegal wins over ECALL, ECALL over EBREAK
    dec.ex_valid = illegal | ecall | ebreak;
    if (illegal) begin
      dec.exc_cause = EXC_CAUSE_ILLEGAL_INSN;
      dec.tval = w;
    end else if (ecall) dec.exc_cause = EXC_CAUSE_ECALL_M;
    else if (ebreak) dec.exc_cause = EXC_CAUSE_BREAKPOINT;
  end

  //////////////////////////////////////////////////
  // Result register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (valid_i) res_q <= dec;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) res_valid_q <= 1'b0;
    else if (valid_i) res_valid_q <= 1'b1;
    else if (take_i) res_valid_q <= 1'b0;
  end

  // A take frees the slot for a new dispatch in the same cycle
  assign busy_o      = res_valid_q & ~take_i;
  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;

  a_no_overwrite: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (valid_i && res_valid_q) |-> take_i)
    else $error("decode_lane: dispatch onto an untaken result");

endmodule

//--- design/decode_pkg.sv
package decode_pkg;

  localparam int XLEN = 64;

  //////////////////////////////////////////////////
  // Instruction word
  //////////////////////////////////////////////////

  // Register-format view of the word
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  // Upper-immediate view of the same word
  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_u_t;

  typedef union packed {
    instr_r_t r;
    instr_u_t u;
  } instr_word_u;

  typedef enum logic [6:0] {
    OPCODE_LOAD      = 7'b0000011,
    OPCODE_MISC_MEM  = 7'b0001111,
    OPCODE_OP_IMM    = 7'b0010011,
    OPCODE_AUIPC     = 7'b0010111,
    OPCODE_OP_IMM_32 = 7'b0011011,
    OPCODE_STORE     = 7'b0100011,
    OPCODE_OP        = 7'b0110011,
    OPCODE_LUI       = 7'b0110111,
    OPCODE_OP_32     = 7'b0111011,
    OPCODE_BRANCH    = 7'b1100011,
    OPCODE_JALR      = 7'b1100111,
    OPCODE_JAL       = 7'b1101111,
    OPCODE_SYSTEM    = 7'b1110011
  } opcode_e;

  //////////////////////////////////////////////////
  // Decoded fields
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {OP_ALU, OP_BRANCH, OP_JUMP, OP_MEM, OP_MUL, OP_DIV} op_type_e;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_SCC, ALU_XOR, ALU_OR, ALU_AND, ALU_SHIFT
  } alu_op_e;

  typedef enum logic [1:0] {SHIFT_OP_SLL, SHIFT_OP_SRL, SHIFT_OP_SRA} shift_op_e;

  // Same values as the branch funct3
  typedef enum logic [2:0] {
    CC_EQ  = 3'b000,
    CC_NE  = 3'b001,
    CC_LT  = 3'b100,
    CC_GE  = 3'b101,
    CC_LTU = 3'b110,
    CC_GEU = 3'b111
  } condition_e;

  typedef enum logic {MEM_LOAD, MEM_STORE} mem_op_e;

  typedef enum logic [3:0] {
    EXC_CAUSE_ILLEGAL_INSN = 4'd2,
    EXC_CAUSE_BREAKPOINT   = 4'd3,
    EXC_CAUSE_ECALL_M      = 4'd11
  } exc_cause_e;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    instr_word_u     instr;
  } fetched_instr_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    op_type_e        op_type;
    alu_op_e         alu_op;
    shift_op_e       shift_op;
    condition_e      condition;
    logic [1:0]      mul_div_op;
    mem_op_e         mem_op;
    logic [1:0]      size;
    logic            zero_ext;
    logic            word_op;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic            use_imm;
    logic            adder_use_pc;
    logic            adder_use_imm;
    logic [XLEN-1:0] immediate;
    logic            ex_valid;
    exc_cause_e      exc_cause;
    logic [31:0]     tval;
  } decoded_instr_t;

  // Starting point of every decode, all fields cleared
  localparam decoded_instr_t DECODED_DEFAULT = '0;

endpackage

//--- design/decode_unit_top.sv
`timescale 1ns/1ps

module decode_unit_top import decode_pkg::*; #(
  parameter int NUM_LANES   = 4,
  parameter int FIFO_DEPTH  = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           in_valid_i,
  input  fetched_instr_t in_instr_i,
  output logic           credit_o,
  output logic           out_valid_o,
  output decoded_instr_t out_instr_o,
  input  logic           credit_i
);

  logic [NUM_LANES-1:0] lane_valid;
  logic [NUM_LANES-1:0] lane_busy;
  fetched_instr_t       lane_instr [NUM_LANES];
  logic [NUM_LANES-1:0] res_valid;
  decoded_instr_t       res [NUM_LANES];
  logic [NUM_LANES-1:0] take;

  fetch_queue #(
    .NUM_LANES  (NUM_LANES),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fetch_queue (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .in_valid_i   (in_valid_i),
    .in_instr_i   (in_instr_i),
    .credit_o     (credit_o),
    .lane_busy_i  (lane_busy),
    .lane_valid_o (lane_valid),
    .lane_instr_o (lane_instr)
  );

  //////////////////////////////////////////////////
  // Decode lanes
  //////////////////////////////////////////////////

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    decode_lane u_lane (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .valid_i     (lane_valid[g]),
      .instr_i     (lane_instr[g]),
      .busy_o      (lane_busy[g]),
      .res_valid_o (res_valid[g]),
      .res_o       (res[g]),
      .take_i      (take[g])
    );
  end

  decode_collector #(
    .NUM_LANES   (NUM_LANES),
    .OUT_CREDITS (OUT_CREDITS)
  ) u_collector (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .res_valid_i (res_valid),
    .res_i       (res),
    .take_o      (take),
    .credit_i    (credit_i),
    .out_valid_o (out_valid_o),
    .out_instr_o (out_instr_o)
  );

endmodule

//--- design/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue import decode_pkg::*; #(
  parameter int NUM_LANES  = 4,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 in_valid_i,
  input  fetched_instr_t       in_instr_i,
  output logic                 credit_o,
  input  logic [NUM_LANES-1:0] lane_busy_i,
  output logic [NUM_LANES-1:0] lane_valid_o,
  output fetched_instr_t       lane_instr_o [NUM_LANES]
);

  localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
  localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam logic [PTR_W-1:0]  LAST_ENTRY = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [LANE_W-1:0] LAST_LANE  = LANE_W'(NUM_LANES - 1);

  fetched_instr_t    mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic [LANE_W-1:0] lane_ptr_q;
  logic              credit_q;
  logic              pop;

  // Head goes out only when the lane in turn can accept it
  assign pop = (count_q != '0) && !lane_busy_i[lane_ptr_q];

  always_comb begin
    lane_valid_o = '0;
    if (pop) lane_valid_o[lane_ptr_q] = 1'b1;
  end

  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane_data
    assign lane_instr_o[k] = mem_q[rd_ptr_q];
  end

  assign credit_o = credit_q;

  always_ff @(posedge clk_i) begin
    if (in_valid_i) mem_q[wr_ptr_q] <= in_instr_i;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      lane_ptr_q <= '0;
      credit_q   <= 1'b0;
    end else begin
      credit_q <= pop;
      if (in_valid_i) wr_ptr_q <= (wr_ptr_q == LAST_ENTRY) ? '0 : wr_ptr_q + 1'b1;
      if (pop) begin
        rd_ptr_q   <= (rd_ptr_q == LAST_ENTRY) ? '0 : rd_ptr_q + 1'b1;
        lane_ptr_q <= (lane_ptr_q == LAST_LANE) ? '0 : lane_ptr_q + 1'b1;
      end
      if (in_valid_i && !pop) count_q <= count_q + 1'b1;
      else if (!in_valid_i && pop) count_q <= count_q - 1'b1;
    end
  end

  // Upstream must hold a credit for every push
  a_no_push_when_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    in_valid_i |-> (count_q < CNT_W'(FIFO_DEPTH)))
    else $error("fetch_queue: push while full");

endmodule

//--- dv/decode_checker.sv
`timescale 1ns/1ps

module decode_checker import decode_pkg::*; #(
  parameter int OUT_CREDITS = 2
) (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           in_valid_i,
  input  fetched_instr_t in_instr_i,
  input  logic           up_credit_i,
  input  logic           out_valid_i,
  input  decoded_instr_t out_instr_i,
  input  logic           dn_credit_i,
  input  logic           end_check_i,
  output int             errors_o,
  output int             checked_o
);

  decoded_instr_t exp_q [$];
  int errors = 0;
  int checked = 0;
  int accepted = 0;
  int up_returned = 0;
  int out_credits = OUT_CREDITS;
  bit after_reset = 1'b0;
  bit end_done = 1'b0;

  assign errors_o  = errors;
  assign checked_o = checked;

  //////////////////////////////////////////////////
  // Reference decode
  //////////////////////////////////////////////////

  function automatic bit is_legal(input logic [31:0] w);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = w[31:25];
    f3 = w[14:12];
    case (w[6:0])
      OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL: return 1'b1;
      OPCODE_JALR, OPCODE_MISC_MEM: return f3 == 3'b000;
      OPCODE_BRANCH: return f3[2:1] != 2'b01;
      OPCODE_LOAD:   return f3 != 3'b111;
      OPCODE_STORE:  return !f3[2];
      // RV64 shifts take a 6-bit shamt
      OPCODE_OP_IMM: begin
        if (f3 == 3'b001) return f7[6:1] == 6'b000000;
        if (f3 == 3'b101) return f7[6:1] inside {6'b000000, 6'b010000};
        return 1'b1;
      end
      OPCODE_OP_IMM_32: begin
        if (f3 == 3'b000) return 1'b1;
        if (f3 == 3'b001) return f7 == 7'b0000000;
        if (f3 == 3'b101) return f7 inside {7'b0000000, 7'b0100000};
        return 1'b0;
      end
      OPCODE_OP:
        return (f7 inside {7'b0000000, 7'b0000001}) ||
               (f7 == 7'b0100000 && f3 inside {3'b000, 3'b101});
      OPCODE_OP_32:
        return (f7 == 7'b0000001 && f3 inside {3'b000, 3'b100, 3'b101, 3'b110, 3'b111}) ||
               (f7 == 7'b0000000 && f3 inside {3'b000, 3'b001, 3'b101}) ||
               (f7 == 7'b0100000 && f3 inside {3'b000, 3'b101});
      OPCODE_SYSTEM: return f3 == 3'b000 && w[31:21] == 11'd0;
      default: return 1'b0;
    endcase
  endfunction

  function automatic decoded_instr_t ref_decode(input fetched_instr_t f);
    decoded_instr_t d;
    logic [31:0] w;
    logic [6:0] opc;
    logic [2:0] f3;
    w   = f.instr;
    opc = w[6:0];
    f3  = w[14:12];
    d    = '0;
    d.pc = f.pc;
    if (!is_legal(w)) begin
      d.ex_valid  = 1'b1;
      d.exc_cause = EXC_CAUSE_ILLEGAL_INSN;
      d.tval      = w;
      return d;
    end
    if (opc == OPCODE_SYSTEM) begin
      d.ex_valid  = 1'b1;
      d.exc_cause = w[20] ? EXC_CAUSE_BREAKPOINT : EXC_CAUSE_ECALL_M;
      return d;
    end
    // Registers the format actually names
    if (!(opc inside {OPCODE_BRANCH, OPCODE_STORE, OPCODE_MISC_MEM})) d.rd = w[11:7];
    if (!(opc inside {OPCODE_JAL, OPCODE_LUI, OPCODE_AUIPC, OPCODE_MISC_MEM})) d.rs1 = w[19:15];
    if (opc inside {OPCODE_BRANCH, OPCODE_STORE, OPCODE_OP, OPCODE_OP_32}) d.rs2 = w[24:20];
    d.word_op = opc inside {OPCODE_OP_IMM_32, OPCODE_OP_32};
    d.adder_use_pc = opc inside {OPCODE_AUIPC, OPCODE_JAL, OPCODE_BRANCH};
    d.adder_use_imm = !(opc inside {OPCODE_OP, OPCODE_OP_32, OPCODE_MISC_MEM});
    d.use_imm = opc inside {OPCODE_OP_IMM, OPCODE_OP_IMM_32};
    case (opc)
      OPCODE_JAL: begin
        d.op_type   = OP_JUMP;
        d.immediate = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      OPCODE_JALR: begin
        d.op_type   = OP_JUMP;
        d.immediate = {{52{w[31]}}, w[31:20]};
      end
      OPCODE_BRANCH: begin
        d.op_type   = OP_BRANCH;
        d.condition = condition_e'(f3);
        d.immediate = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      end
      OPCODE_LOAD, OPCODE_STORE: begin
        d.op_type   = OP_MEM;
        d.size      = f3[1:0];
        d.mem_op    = (opc == OPCODE_STORE) ? MEM_STORE : MEM_LOAD;
        d.zero_ext  = (opc == OPCODE_LOAD) && f3[2];
        d.immediate = (opc == OPCODE_STORE) ? {{52{w[31]}}, w[31:25], w[11:7]}
                                            : {{52{w[31]}}, w[31:20]};
      end
      OPCODE_LUI, OPCODE_AUIPC: d.immediate = {{32{w[31]}}, w[31:12], 12'b0};
      OPCODE_MISC_MEM: ;
      default: begin
        if (d.use_imm) d.immediate = {{52{w[31]}}, w[31:20]};
        if (!d.use_imm && w[31:25] == 7'b0000001) begin
          d.op_type    = f3[2] ? OP_DIV : OP_MUL;
          d.mul_div_op = f3[1:0];
        end else begin
          case (f3)
            3'b000: d.alu_op = (!d.use_imm && w[30]) ? ALU_SUB : ALU_ADD;
            3'b001: d.alu_op = ALU_SHIFT;
            3'b010: {d.alu_op, d.condition} = {ALU_SCC, CC_LT};
            3'b011: {d.alu_op, d.condition} = {ALU_SCC, CC_LTU};
            3'b100: d.alu_op = ALU_XOR;
            3'b101: {d.alu_op, d.shift_op} = {ALU_SHIFT, w[30] ? SHIFT_OP_SRA : SHIFT_OP_SRL};
            3'b110: d.alu_op = ALU_OR;
            default: d.alu_op = ALU_AND;
          endcase
        end
      end
    endcase
    return d;
  endfunction

  // Other fields of an illegal word carry no meaning
  function automatic decoded_instr_t exception_view(input decoded_instr_t d);
    decoded_instr_t v;
    v           = '0;
    v.pc        = d.pc;
    v.ex_valid  = d.ex_valid;
    v.exc_cause = d.exc_cause;
    v.tval      = d.tval;
    return v;
  endfunction

  task automatic compare_result(input decoded_instr_t exp, input decoded_instr_t act);
    string name;
    decoded_instr_t e;
    decoded_instr_t a;
    e    = exp;
    a    = act;
    name = exp.ex_valid ? "exception_decode" : "legal_decode";
    if (exp.ex_valid && exp.exc_cause == EXC_CAUSE_ILLEGAL_INSN) begin
      name = "illegal_decode";
      e    = exception_view(exp);
      a    = exception_view(act);
    end
    checked++;
    if (a !== e) begin
      errors++;
      $display("CHECK FAILED %s pc=%h expected=%h actual=%h", name, exp.pc, e, a);
    end
  endtask

  //////////////////////////////////////////////////
  // Monitor
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!arst_n_i) begin
      exp_q.delete();
      out_credits = OUT_CREDITS;
      accepted    = 0;
      up_returned = 0;
      after_reset = 1'b1;
    end else begin
      if (after_reset) begin
        after_reset = 1'b0;
        if (up_credit_i !== 1'b0 || out_valid_i !== 1'b0) begin
          errors++;
          $display("CHECK FAILED reset_outputs expected=0,0 actual=%b,%b",
                   up_credit_i, out_valid_i);
        end
      end
      if (in_valid_i) begin
        exp_q.push_back(ref_decode(in_instr_i));
        accepted++;
      end
      if (up_credit_i) up_returned++;
      if (out_valid_i) begin
        if (out_credits <= 0) begin
          errors++;
          $display("ERROR: DUT sent an instruction without holding a downstream credit");
        end
        out_credits--;
        if (exp_q.size() == 0) begin
          errors++;
          $display("ERROR: DUT sent pc %h with no instruction outstanding", out_instr_i.pc);
        end else begin
          compare_result(exp_q.pop_front(), out_instr_i);
        end
      end
      if (dn_credit_i) out_credits++;
      if (end_check_i && !end_done) begin
        end_done = 1'b1;
        if (exp_q.size() != 0) begin
          errors++;
          $display("ERROR: %0d accepted instructions never came out", exp_q.size());
        end
        if (up_returned != accepted) begin
          errors++;
          $display("CHECK FAILED upstream_credits expected=%0d actual=%0d",
                   accepted, up_returned);
        end
      end
    end
  end

endmodule

//--- dv/tb_top.sv
`timescale 1ns/1ps

module tb_top import decode_pkg::*; ();

  localparam int NUM_LANES      = 4;
  localparam int FIFO_DEPTH     = 4;
  localparam int OUT_CREDITS    = 2;
  localparam int NUM_INSTR      = 600;
  localparam int CREDIT_TIMEOUT = 1000;
  localparam int DRAIN_TIMEOUT  = 2000;
  localparam int DRIVE_DLY      = 2;
  localparam logic [31:0] REG_MASK = 32'h000F_8F80;
  localparam logic [31:0] RS2_MASK = 32'h01F0_0000;

  // Kept encodings first, then dropped and malformed ones
  localparam logic [31:0] ENC_TABLE [80] = '{
    32'h0000006f, 32'h00000067, 32'h00000063, 32'h00001063,
    32'h00004063, 32'h00005063, 32'h00006063, 32'h00007063,
    32'h00000003, 32'h00001003, 32'h00002003, 32'h00003003,
    32'h00004003, 32'h00005003, 32'h00006003, 32'h00000023,
    32'h00001023, 32'h00002023, 32'h00003023, 32'h00000037,
    32'h00000017, 32'h00000013, 32'h00002013, 32'h00003013,
    32'h00004013, 32'h00006013, 32'h00007013, 32'h00001013,
    32'h00005013, 32'h40005013, 32'h02001013, 32'h0000001b,
    32'h0000101b, 32'h0000501b, 32'h4000501b, 32'h00000033,
    32'h40000033, 32'h00001033, 32'h00002033, 32'h00003033,
    32'h00004033, 32'h00005033, 32'h40005033, 32'h00006033,
    32'h00007033, 32'h02000033, 32'h02001033, 32'h02002033,
    32'h02003033, 32'h02004033, 32'h02005033, 32'h02006033,
    32'h02007033, 32'h0000003b, 32'h4000003b, 32'h0000103b,
    32'h0000503b, 32'h4000503b, 32'h0200003b, 32'h0200403b,
    32'h0200503b, 32'h0200603b, 32'h0200703b, 32'h0ff0000f,
    32'h00000073, 32'h00100073, 32'h30200073, 32'h30001073,
    32'h00002007, 32'h00002027, 32'h0000202f, 32'h0000100f,
    32'h08000033, 32'h0200101b, 32'h20005013, 32'h10500073,
    32'h12000073, 32'h0000203b, 32'h0200103b, 32'h00007003
  };

  localparam logic [6:0] KEPT_OPCODES [13] = '{
    7'h03, 7'h0f, 7'h13, 7'h17, 7'h1b, 7'h23, 7'h33,
    7'h37, 7'h3b, 7'h63, 7'h67, 7'h6f, 7'h73
  };

  logic           clk;
  logic           arst_n;
  logic           in_valid;
  fetched_instr_t in_instr;
  logic           up_credit;
  logic           out_valid;
  decoded_instr_t out_instr;
  logic           dn_credit;
  logic           end_check;
  int             chk_errors;
  int             chk_checked;
  bit             timed_out = 1'b0;
  int             up_sent = 0;
  int             up_returned = 0;
  int             dn_received = 0;
  int             dn_returned = 0;
  int             dn_cycle = 0;

  decode_unit_top #(
    .NUM_LANES   (NUM_LANES),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) dut (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .in_valid_i  (in_valid),
    .in_instr_i  (in_instr),
    .credit_o    (up_credit),
    .out_valid_o (out_valid),
    .out_instr_o (out_instr),
    .credit_i    (dn_credit)
  );

  decode_checker #(
    .OUT_CREDITS (OUT_CREDITS)
  ) u_checker (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .in_valid_i  (in_valid),
    .in_instr_i  (in_instr),
    .up_credit_i (up_credit),
    .out_valid_i (out_valid),
    .out_instr_i (out_instr),
    .dn_credit_i (dn_credit),
    .end_check_i (end_check),
    .errors_o    (chk_errors),
    .checked_o   (chk_checked)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper LCG bits pick the kind of word since the low bits are too regular
  function automatic logic [31:0] pick_word(input logic [31:0] r1, input logic [31:0] r2);
    logic [31:0] enc;
    logic [31:0] mask;
    enc  = ENC_TABLE[r1[23:16] % 80];
    // In a SYSTEM word the rs2 bits belong to funct12
    mask = (enc[6:0] == 7'h73) ? REG_MASK : (REG_MASK | RS2_MASK);
    case (r1[31:30])
      2'd0: return r2;
      2'd1: return {r2[31:7], KEPT_OPCODES[r1[23:16] % 13]};
      default: return (enc & ~mask) | (r2 & mask);
    endcase
  endfunction

  task automatic send_instr(input fetched_instr_t item);
    int waited;
    waited = 0;
    while (!timed_out && FIFO_DEPTH + up_returned - up_sent == 0) begin
      @(posedge clk);
      #(DRIVE_DLY);
      waited++;
      if (waited > CREDIT_TIMEOUT) begin
        $display("Timeout: no upstream credit came back for %0d cycles", CREDIT_TIMEOUT);
        timed_out = 1'b1;
      end
    end
    if (!timed_out) begin
      in_valid = 1'b1;
      in_instr = item;
      up_sent++;
      @(posedge clk);
      #(DRIVE_DLY);
      in_valid = 1'b0;
    end
  endtask

  // Credit and output counts seen at the clock edge
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      up_returned <= 0;
      dn_received <= 0;
    end else begin
      if (up_credit) up_returned <= up_returned + 1;
      if (out_valid) dn_received <= dn_received + 1;
    end
  end

  //////////////////////////////////////////////////
  // Downstream credit return with long pauses
  //////////////////////////////////////////////////

  initial begin
    dn_credit = 1'b0;
    forever begin
      @(posedge clk);
      #(DRIVE_DLY);
      dn_credit = 1'b0;
      dn_cycle++;
      if (arst_n && dn_received > dn_returned && (dn_cycle % 300) >= 120 &&
          (dn_cycle % 3) != 0) begin
        dn_credit = 1'b1;
        dn_returned++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus and end of run
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] rng;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    fetched_instr_t item;
    int waited;
    rng       = 32'h5559_3c0d;
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    in_instr  = '0;
    end_check = 1'b0;
    repeat (2) @(posedge clk);
    #(DRIVE_DLY);
    arst_n = 1'b1;
    for (int n = 0; n < NUM_INSTR && !timed_out; n++) begin
      rng = lcg_next(rng);
      r1  = rng;
      rng = lcg_next(rng);
      r2  = rng;
      rng = lcg_next(rng);
      r3  = rng;
      item.pc    = {r3, r2 ^ r1};
      item.instr = pick_word(r1, r2);
      send_instr(item);
      // Occasional idle cycle on the input
      if (r3[31:30] == 2'd0) begin
        @(posedge clk);
        #(DRIVE_DLY);
      end
    end
    // Drained once every output is seen and all upstream credits are back
    waited = 0;
    while (!timed_out && (dn_received != up_sent || up_returned != up_sent)) begin
      @(posedge clk);
      #(DRIVE_DLY);
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        $display("Timeout: DUT did not drain within %0d cycles", DRAIN_TIMEOUT);
        timed_out = 1'b1;
      end
    end
    end_check = 1'b1;
    repeat (2) @(posedge clk);
    #(DRIVE_DLY);
    $display("Summary: %0d sent, %0d received, %0d checked, %0d errors",
             up_sent, dn_received, chk_checked, chk_errors);
    if (!timed_out && chk_errors == 0 && chk_checked == up_sent) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
design/decode_pkg.sv
design/fetch_queue.sv
design/decode_lane.sv
design/decode_collector.sv
design/decode_unit_top.sv
dv/decode_checker.sv
dv/tb_top.sv
